/* dv/pedal_asserts.sv */
`timescale 1ns/1ps

module pedal_asserts
   import pedal_pkg::*;
(
   input logic               clk,
   input logic               rst,
   input logic               in_req,
   input logic               in_ack,
   input logic               out_req,
   input logic               out_ack,
   input logic signed [15:0] out_sample,
   input ctrl_word_t         status,
   input level_state_t       state       // audio_level fsm state
);

   int fail_count = 0;  // failed checks so far

   // ack only answers a request that is already up
   ack_after_req: assert property (@(posedge clk) disable iff (rst)
      $rose(in_ack) |-> $past(in_req))
      else begin
         $error("in_ack rose without in_req");
         fail_count++;
      end

   // output held until the sink takes it
   out_held: assert property (@(posedge clk) disable iff (rst)
      out_req && !out_ack |=> out_req && $stable(out_sample))
      else begin
         $error("out_req or out_sample changed before out_ack");
         fail_count++;
      end

   // a new sample is only taken once the output handshake has closed
   no_ack_in_output: assert property (@(posedge clk) disable iff (rst)
      $rose(in_ack) |-> $past(!out_req && !out_ack))
      else begin
         $error("in_ack during output handshake");
         fail_count++;
      end

   // knob moves one step at a time, 5 bits so 0 and 15 never look adjacent
   vol_one_step: assert property (@(posedge clk) disable iff (rst)
      $stable(status.volume)
      || ({1'b0, status.volume} == {1'b0, $past(status.volume)} + 5'd1)
      || ({1'b0, $past(status.volume)} == {1'b0, status.volume} + 5'd1))
      else begin
         $error("volume jumped by more than one");
         fail_count++;
      end

   // everything cleared right after reset
   reset_clear: assert property (@(posedge clk)
      $fell(rst) |-> !in_ack && !out_req && (status == '0) && (out_sample == '0)
      && (state == IDLE))
      else begin
         $error("outputs not zero after reset");
         fail_count++;
      end

endmodule

bind pedal_top pedal_asserts i_pedal_asserts (
   .clk        (clk),
   .rst        (rst),
   .in_req     (in_req),
   .in_ack     (in_ack),
   .out_req    (out_req),
   .out_ack    (out_ack),
   .out_sample (out_sample),
   .status     (status),
   .state      (i_audio_level.state)
);

/* dv/pedal_tb.sv */
`timescale 1ns/1ps

module pedal_tb
   import pedal_pkg::*;
;

   localparam int TMO = 200;                    // handshake wait limit
   localparam int SETTLE = DEBOUNCE_CYCLES + 20; // panel settle limit

   logic clk;
   logic rst;
   logic [3:0] pbs;
   logic [1:0] vol;
   logic in_req;
   logic signed [15:0] in_sample;
   logic in_ack;
   logic out_req;
   logic out_ack;
   logic signed [15:0] out_sample;
   ctrl_word_t status;

   ctrl_word_t exp_status;          // model of the panel state
   logic signed [15:0] exp_out;     // model of the next output sample
   bit check_en;                    // status check armed
   int pos;                         // knob position in gray sequence
   logic [1:0] gray [4] = '{2'b00, 2'b01, 2'b11, 2'b10};

   pedal_top i_pedal_top (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic report_mismatch(string msg);
      $display("FAIL at %0t ns: %s", $time, msg);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
   endtask

   task automatic stop_on_timeout(string what);
      $display("TEST FAIL");
      $fatal(1, "timed out waiting for %s", what);
   endtask

   // bound protocol checks stop the run too
   always @(posedge clk) begin
      if (i_pedal_top.i_pedal_asserts.fail_count != 0) begin
         $display("TEST FAIL");
         $fatal(1, "protocol assertion failed");
      end
   end

   status_matches: assert property (@(posedge clk) disable iff (rst)
      check_en |-> status == exp_status)
      else report_mismatch($sformatf("status %h expected %h", status, exp_status));

   sample_matches: assert property (@(posedge clk) disable iff (rst)
      $rose(out_req) |-> out_sample == exp_out)
      else report_mismatch($sformatf("out_sample %0d expected %0d", out_sample, exp_out));

   // gate, clip, mute, then scale by volume/16
   function automatic logic signed [15:0] level_model(int x, ctrl_word_t c);
      int y;
      y = x;
      if (c.noise_gate && y > -int'(NG_THRESHOLD) && y < int'(NG_THRESHOLD)) y = 0;
      else if (c.effect && y > int'(CLIP_LEVEL)) y = int'(CLIP_LEVEL);
      else if (c.effect && y < -int'(CLIP_LEVEL)) y = -int'(CLIP_LEVEL);
      if (c.mute && !c.ptt) y = 0;   // ptt beats mute
      y = (y * int'(c.volume)) >>> 4;
      return y[15:0];
   endfunction

   task automatic wait_status(int limit);
      int n;
      n = 0;
      while (status !== exp_status) begin
         if (n >= limit) stop_on_timeout("status to settle");
         n++;
         @(posedge clk);
      end
      check_en = 1'b1;
   endtask

   task automatic btn_down(int i);
      @(posedge clk);
      pbs[i] <= 1'b1;
      check_en = 1'b0;
      if (i == 0) exp_status.ptt = 1'b1;
      if (i == 1) exp_status.mute = ~exp_status.mute;
      if (i == 2) exp_status.effect = ~exp_status.effect;
      if (i == 3) exp_status.noise_gate = ~exp_status.noise_gate;
      wait_status(SETTLE);
   endtask

   task automatic btn_up(int i);
      @(posedge clk);
      pbs[i] <= 1'b0;
      check_en = 1'b0;
      if (i == 0) exp_status.ptt = 1'b0;
      wait_status(SETTLE);
      repeat (DEBOUNCE_CYCLES + 10) @(posedge clk);  // release must not toggle
   endtask

   task automatic knob_step(bit cw);
      @(posedge clk);
      pos = cw ? (pos + 1) % 4 : (pos + 3) % 4;
      vol <= gray[pos];
      check_en = 1'b0;
      if (cw && exp_status.volume < VOL_MAX) exp_status.volume++;
      if (!cw && exp_status.volume != 0) exp_status.volume--;
      wait_status(TMO);
   endtask

   task automatic set_volume(int target);
      while (exp_status.volume < target) knob_step(1'b1);
      while (exp_status.volume > target) knob_step(1'b0);
   endtask

   task automatic set_modes(bit m, bit e, bit g);
      if (exp_status.mute != m) begin
         btn_down(1);
         btn_up(1);
      end
      if (exp_status.effect != e) begin
         btn_down(2);
         btn_up(2);
      end
      if (exp_status.noise_gate != g) begin
         btn_down(3);
         btn_up(3);
      end
   endtask

   // source side, full four-phase input handshake
   task automatic put_sample(logic signed [15:0] s);
      int n;
      @(posedge clk);
      in_sample <= s;
      in_req <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         if (++n > TMO) stop_on_timeout("in_ack");
      end while (!in_ack);
      in_req <= 1'b0;
      n = 0;
      do begin
         @(posedge clk);
         if (++n > TMO) stop_on_timeout("in_ack to drop");
      end while (in_ack);
   endtask

   // sink side, random delay before out_ack
   task automatic take_sample();
      int n;
      n = 0;
      while (!out_req) begin
         @(posedge clk);
         if (++n > TMO) stop_on_timeout("out_req");
      end
      repeat ($urandom % 6) @(posedge clk);  // sink back-pressure
      out_ack <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         if (++n > TMO) stop_on_timeout("out_req to drop");
      end while (out_req);
      out_ack <= 1'b0;
   endtask

   task automatic send_sample(logic signed [15:0] s);
      exp_out = level_model(int'(s), exp_status);
      put_sample(s);
      take_sample();
   endtask

   // second sample requested while the first one is still held at the output
   task automatic send_pair(logic signed [15:0] s0, logic signed [15:0] s1);
      exp_out = level_model(int'(s0), exp_status);
      fork
         begin
            put_sample(s0);
            put_sample(s1);
         end
         begin
            take_sample();
            exp_out = level_model(int'(s1), exp_status);
            take_sample();
         end
      join
   endtask

   initial begin
      int n;
      void'($urandom(92));
      rst = 1'b1;
      pbs = '0;
      vol = '0;
      in_req = 1'b0;
      in_sample = '0;
      out_ack = 1'b0;
      exp_status = '0;
      exp_out = '0;
      check_en = 1'b0;
      pos = 0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      wait_status(TMO);
      // toggles on and back off
      for (int i = 1; i < 4; i++) begin
         btn_down(i);
         btn_up(i);
      end
      for (int i = 1; i < 4; i++) begin
         btn_down(i);
         btn_up(i);
      end
      // short pulse and chatter, status must hold
      @(posedge clk) pbs[1] <= 1'b1;
      repeat (DEBOUNCE_CYCLES / 2) @(posedge clk);
      pbs[1] <= 1'b0;
      repeat (5) begin
         repeat (DEBOUNCE_CYCLES / 5) @(posedge clk);
         pbs[2] <= 1'b1;
         repeat (DEBOUNCE_CYCLES / 5) @(posedge clk);
         pbs[2] <= 1'b0;
      end
      repeat (DEBOUNCE_CYCLES + 10) @(posedge clk);
      // knob range and saturation
      repeat (20) knob_step(1'b1);
      repeat (20) knob_step(1'b0);
      set_volume(8);                 // mid range, a wrong step shows either way
      @(posedge clk) vol <= 2'b11;   // two-bit jump, ignored
      repeat (8) @(posedge clk);
      vol <= 2'b00;
      repeat (8) @(posedge clk);
      // directed sample cases
      set_volume(15);
      set_modes(1'b0, 1'b0, 1'b1);
      send_sample(16'sd100);
      send_sample(-16'sd255);
      set_modes(1'b0, 1'b1, 1'b0);
      send_sample(16'sd20000);
      send_sample(-16'sd30000);
      set_modes(1'b1, 1'b0, 1'b0);
      send_sample(16'sd12345);
      btn_down(0);
      send_sample(16'sd12345);
      btn_up(0);
      // random samples over all mode combinations
      for (int c = 0; c < 8; c++) begin
         set_modes(c[0], c[1], c[2]);
         for (int k = 0; k < 6; k++) begin
            set_volume($urandom % 16);
            send_pair(16'($urandom), 16'($urandom));
         end
      end
      // reset in the middle of an input handshake
      @(posedge clk);
      in_sample <= 16'sd1000;
      in_req <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         if (++n > TMO) stop_on_timeout("in_ack before reset");
      end while (!in_ack);
      check_en = 1'b0;
      rst <= 1'b1;
      in_req <= 1'b0;
      vol <= 2'b00;
      pos = 0;
      exp_status = '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      wait_status(TMO);
      set_volume(8);
      send_sample(16'sd4000);
      send_sample(-16'sd4000);
      @(posedge clk);
      if (i_pedal_top.i_pedal_asserts.fail_count == 0) begin
         $display("TEST PASS");
         $finish;
      end else begin
         $display("TEST FAIL");
         $fatal(1, "protocol assertion failed");
      end
   end

endmodule

/* filelist.f */
hw/pedal_pkg.sv
hw/panel_buttons.sv
hw/volume_knob.sv
hw/ctrl_merge.sv
hw/audio_level.sv
hw/pedal_top.sv
dv/pedal_asserts.sv
dv/pedal_tb.sv

/* hw/audio_level.sv */
`timescale 1ns/1ps

module audio_level
   import pedal_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  ctrl_word_t         ctrl,        // live control word
   input  logic               in_req,
   input  logic signed [15:0] in_sample,
   output logic               in_ack,
   output logic               out_req,
   input  logic               out_ack,
   output logic signed [15:0] out_sample
);

   level_state_t       state;
   logic               take;      // accept a new sample this cycle
   logic signed [15:0] smp_q;     // captured sample
   ctrl_word_t         ctrl_q;    // control word captured with it
   logic signed [15:0] gated;
   logic signed [15:0] clipped;
   logic signed [15:0] muted;
   logic signed [20:0] prod;      // sample times volume
   logic signed [15:0] result;

   assign take = (state == IDLE) && in_req && !out_ack;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE:     if (take) state <= HOLD_IN;
            HOLD_IN:  if (!in_req) state <= SEND;      // source released
            SEND:     if (out_ack) state <= WAIT_REL;  // sink took it
            WAIT_REL: if (!out_ack) state <= IDLE;     // sink released
            default:  state <= IDLE;
         endcase
      end
   end

   assign in_ack  = (state == HOLD_IN);
   assign out_req = (state == SEND);

   // sample and ctrl snapshot
   always_ff @(posedge clk) begin
      if (take) begin
         smp_q  <= in_sample;
         ctrl_q <= ctrl;
      end
   end

   always_comb begin
      // noise gate, |x| < threshold
      if (ctrl_q.noise_gate && (smp_q > -NG_THRESHOLD) && (smp_q < NG_THRESHOLD)) begin
         gated = '0;
      end else begin
         gated = smp_q;
      end
      clipped = gated;
      if (ctrl_q.effect) begin
         if (gated > CLIP_LEVEL) begin
            clipped = CLIP_LEVEL;
         end else if (gated < -CLIP_LEVEL) begin
            clipped = -CLIP_LEVEL;
         end
      end
      muted  = (ctrl_q.mute && !ctrl_q.ptt) ? '0 : clipped;  // ptt overrides mute
      prod   = muted * $signed({1'b0, ctrl_q.volume});
      result = prod[19:4];  // >>> 4, |result| stays below 2^15
   end

   // result held from HOLD_IN through the output handshake
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_sample <= '0;
      end else if (state == HOLD_IN) begin
         out_sample <= result;
      end
   end

endmodule

/* hw/ctrl_merge.sv */
`timescale 1ns/1ps

module ctrl_merge
   import pedal_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  btn_modes_t modes,   // from panel_buttons
   input  logic [3:0] volume,  // from volume_knob
   output ctrl_word_t ctrl     // registered snapshot for audio stage and status
);

   ctrl_word_t ctrl_next;  // combined panel state

   always_comb begin
      ctrl_next.volume     = volume;
      ctrl_next.mute       = modes.mute;
      ctrl_next.effect     = modes.effect;
      ctrl_next.noise_gate = modes.noise_gate;
      ctrl_next.ptt        = modes.ptt;
   end

   // single register so both consumers see the same word
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ctrl <= '0;
      end else begin
         ctrl <= ctrl_next;
      end
   end

endmodule

/* hw/panel_buttons.sv */
`timescale 1ns/1ps

module panel_buttons
   import pedal_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic [3:0] pbs,    // raw push-buttons, bit 0 is ptt
   output btn_modes_t modes   // toggled modes and ptt level
);

   logic [3:0] sync_0;                    // first sync stage
   logic [3:0] sync_1;                    // second sync stage
   logic [3:0][DB_CNT_W-1:0] db_cnt;      // one debounce counter per button
   logic [3:0] db_lvl;                    // debounced levels
   logic [3:0] db_dly;                    // debounced levels, one cycle later
   logic [3:0] db_prev;                   // previous level for edge detect
   logic [3:0] rise;                      // debounced rising edges

   // two-stage synchronizer
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sync_0 <= '0;
         sync_1 <= '0;
      end else begin
         sync_0 <= pbs;
         sync_1 <= sync_0;
      end
   end

   // counter restarts whenever the input agrees with the debounced level,
   // so a chattering button never builds up a count
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         db_cnt <= '0;
         db_lvl <= '0;
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (sync_1[i] == db_lvl[i]) begin
               db_cnt[i] <= '0;                 // stable, nothing pending
            end else if (db_cnt[i] == DB_LAST) begin
               db_cnt[i] <= '0;
               db_lvl[i] <= sync_1[i];          // held long enough, take it
            end else begin
               db_cnt[i] <= db_cnt[i] + 1'b1;   // still counting
            end
         end
      end
   end

   // edge detect pipeline
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         db_dly  <= '0;
         db_prev <= '0;
      end else begin
         db_dly  <= db_lvl;
         db_prev <= db_dly;
      end
   end

   assign rise = db_dly & ~db_prev;  // one-cycle pulse per press

   // mode register
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         modes <= '0;
      end else begin
         modes.ptt <= db_dly[0];                // follows button level
         if (rise[1]) begin
            modes.mute <= ~modes.mute;
         end
         if (rise[2]) begin
            modes.effect <= ~modes.effect;
         end
         if (rise[3]) begin
            modes.noise_gate <= ~modes.noise_gate;
         end
      end
   end

endmodule

/* hw/pedal_pkg.sv */
package pedal_pkg;

   // button debounce
   localparam int DEBOUNCE_CYCLES = 5000;                 // cycles a change must hold
   localparam int DB_CNT_W = $clog2(DEBOUNCE_CYCLES);     // 13 bits for 5000
   localparam logic [DB_CNT_W-1:0] DB_LAST = DB_CNT_W'(DEBOUNCE_CYCLES - 1); // terminal count

   // audio levels, signed sample units
   localparam logic signed [15:0] NG_THRESHOLD = 16'sd256;  // gate when |x| below this
   localparam logic signed [15:0] CLIP_LEVEL = 16'sd8192;   // hard clip limit, +/-

   // knob
   localparam logic [3:0] VOL_MAX = 4'd15;                 // top of volume range

   // toggled and held panel modes
   typedef struct packed {
      logic mute;        // toggled by button 1
      logic effect;      // toggled by button 2
      logic noise_gate;  // toggled by button 3
      logic ptt;         // level of button 0
   } btn_modes_t;

   // registered pedal control word
   typedef struct packed {
      logic [3:0] volume;  // 0..VOL_MAX
      logic mute;
      logic effect;
      logic noise_gate;
      logic ptt;
   } ctrl_word_t;

   // audio_level handshake states
   typedef enum logic [1:0] {
      IDLE     = 2'd0,  // waiting for in_req
      HOLD_IN  = 2'd1,  // in_ack high, result computed
      SEND     = 2'd2,  // out_req high until out_ack
      WAIT_REL = 2'd3   // waiting for out_ack to drop
   } level_state_t;

endpackage

/* hw/pedal_top.sv */
`timescale 1ns/1ps

module pedal_top
   import pedal_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic [3:0]         pbs,         // push-buttons
   input  logic [1:0]         vol,         // volume knob
   input  logic               in_req,
   input  logic signed [15:0] in_sample,
   output logic               in_ack,
   output logic               out_req,
   input  logic               out_ack,
   output logic signed [15:0] out_sample,
   output ctrl_word_t         status       // current control word
);

   btn_modes_t modes;   // button modes to merge
   logic [3:0] volume;  // knob volume to merge

   panel_buttons i_panel_buttons (
      .clk   (clk),
      .rst   (rst),
      .pbs   (pbs),
      .modes (modes)
   );

   volume_knob i_volume_knob (
      .clk    (clk),
      .rst    (rst),
      .vol    (vol),
      .volume (volume)
   );

   ctrl_merge i_ctrl_merge (
      .clk    (clk),
      .rst    (rst),
      .modes  (modes),
      .volume (volume),
      .ctrl   (status)
   );

   audio_level i_audio_level (
      .clk        (clk),
      .rst        (rst),
      .ctrl       (status),
      .in_req     (in_req),
      .in_sample  (in_sample),
      .in_ack     (in_ack),
      .out_req    (out_req),
      .out_ack    (out_ack),
      .out_sample (out_sample)
   );

endmodule

/* hw/volume_knob.sv */
`timescale 1ns/1ps

module volume_knob
   import pedal_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic [1:0] vol,     // quadrature knob phases
   output logic [3:0] volume   // saturating 0..VOL_MAX
);

   logic [1:0] sync_0;     // first sync stage
   logic [1:0] sync_1;     // second sync stage
   logic [1:0] prev_code;  // last synchronized code
   logic       cw;         // clockwise step
   logic       acw;        // anticlockwise step

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         sync_0    <= '0;
         sync_1    <= '0;
         prev_code <= '0;
      end else begin
         sync_0    <= vol;
         sync_1    <= sync_0;
         prev_code <= sync_1;
      end
   end

   // gray sequence 00 -> 01 -> 11 -> 10 is clockwise
   always_comb begin
      cw  = 1'b0;
      acw = 1'b0;
      case ({prev_code, sync_1})
         4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: cw  = 1'b1;
         4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: acw = 1'b1;
         default: ;  // no change or two-bit jump, ignored
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         volume <= '0;
      end else if (cw && (volume < VOL_MAX)) begin
         volume <= volume + 1'b1;   // step up, stop at max
      end else if (acw && (volume != '0)) begin
         volume <= volume - 1'b1;   // step down, stop at zero
      end
   end

endmodule
